/* logic/ps2_pkg.sv */
// --------------------------------------
// PS/2 line protocol constants
// Frame layout and receive timeout
// --------------------------------------

package ps2_pkg;

    // Frame is start, 8 data bits LSB first, odd parity, stop
    localparam int FRAME_BITS = 11;     // Bits per frame on the wire

    // Positions in the shift register once the whole frame is in
    localparam int DATA_LSB   = 1;      // First data bit, right after start
    localparam int PARITY_POS = 9;      // Odd parity over bits 1..9

    // --------------------------------------
    // Idle timeout
    // --------------------------------------
    // Keyboard clock runs at 10..16.7 kHz, so a gap this long
    // in the middle of a frame means the frame was cut off
    localparam int RX_TIMEOUT_CYCLES = 2000;    // System clocks without a falling edge
    localparam int RX_TIMER_W = $clog2(RX_TIMEOUT_CYCLES + 1);

endpackage

/* logic/key_pkg.sv */
// --------------------------------------
// Key event constants
// Set 2 prefixes, event queue and credit sizing
// --------------------------------------

package key_pkg;

    // --------------------------------------
    // Scan code set 2 prefix bytes
    // --------------------------------------
    localparam logic [7:0] PREFIX_EXTENDED = 8'hE0;  // Extended key follows
    localparam logic [7:0] PREFIX_RELEASE  = 8'hF0;  // Break code follows

    // --------------------------------------
    // Event FIFO
    // --------------------------------------
    localparam int QUEUE_DEPTH = 8;                     // Stored events
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);   // Read and write pointers

    // --------------------------------------
    // Consumer flow control
    // --------------------------------------
    // Consumer starts with this many free slots and never
    // hands back more than it has been given, so the counter
    // never has to hold more than the initial value
    localparam int CONSUMER_CREDITS = 4;
    localparam int CREDIT_W = $clog2(CONSUMER_CREDITS + 1);

endpackage

/* logic/ps2_frame_rx.sv */
// --------------------------------------
// PS/2 frame receiver
// Line synchronizers, falling edge detect,
// 11-bit shifter, frame check, idle timeout
// --------------------------------------

`timescale 1ns/1ns

module ps2_frame_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,       // Async from keyboard
    input  logic       ps2_data,      // Async from keyboard
    output logic       byte_valid,    // One-cycle pulse with byte_data
    output logic [7:0] byte_data,
    output logic       frame_error    // One-cycle pulse, bad start/stop/parity
);

    logic clk_meta;                   // First sync stage
    logic clk_sync;                   // Second sync stage
    logic clk_last;                   // Previous clk_sync, for edge detect
    logic data_meta;
    logic data_sync;
    logic clk_fall;

    logic [ps2_pkg::FRAME_BITS-1:0] shreg;     // Bits received so far
    logic [ps2_pkg::FRAME_BITS-1:0] frame;     // Frame including the bit arriving now
    logic [3:0]                     bit_cnt;   // Bits already shifted in
    logic [ps2_pkg::RX_TIMER_W-1:0] idle_timer;
    logic                           last_bit;
    logic                           frame_ok;

    // --------------------------------------
    // Synchronizers
    // --------------------------------------
    // Both lines idle high, so reset to 1 and no false edge comes out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_meta  <= 1'b1;
            clk_sync  <= 1'b1;
            clk_last  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
        end else begin
            clk_meta  <= ps2_clk;
            clk_sync  <= clk_meta;
            clk_last  <= clk_sync;
            data_meta <= ps2_data;
            data_sync <= data_meta;    // Same depth as clock path, stays aligned
        end
    end

    assign clk_fall = clk_last & ~clk_sync;    // Keyboard drives data on the falling edge

    // --------------------------------------
    // Frame assembly and check
    // --------------------------------------
    // LSB first, so the newest bit enters at the top
    assign frame    = {data_sync, shreg[ps2_pkg::FRAME_BITS-1:1]};
    assign last_bit = (bit_cnt == 4'(ps2_pkg::FRAME_BITS - 1));

    // Start low, stop high, odd parity over data plus parity bit
    assign frame_ok = (frame[0] == 1'b0)
                   && (frame[ps2_pkg::FRAME_BITS-1] == 1'b1)
                   && (^frame[ps2_pkg::PARITY_POS:ps2_pkg::DATA_LSB] == 1'b1);

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shreg <= frame;
        end
        if (clk_fall && last_bit) begin
            byte_data <= frame[ps2_pkg::DATA_LSB +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= '0;
            idle_timer  <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;      // Pulses by default
            frame_error <= 1'b0;
            if (clk_fall) begin
                idle_timer <= '0;     // Every edge restarts the timeout
                if (last_bit) begin
                    bit_cnt     <= '0;           // Accept on the 11th edge
                    byte_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != '0) begin
                // Partial frame pending, watch for the keyboard going silent
                if (idle_timer == (ps2_pkg::RX_TIMER_W)'(ps2_pkg::RX_TIMEOUT_CYCLES)) begin
                    bit_cnt    <= '0;            // Drop it quietly, no error pulse
                    idle_timer <= '0;
                end else begin
                    idle_timer <= idle_timer + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/scan_event_decoder.sv */
// --------------------------------------
// Scan code set 2 prefix decoder
// E0/F0 flags, key events, last make code for LEDs
// --------------------------------------

`timescale 1ns/1ns

module scan_event_decoder (
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       frame_error,
    output logic       event_valid,      // One-cycle pulse
    output logic [7:0] event_code,
    output logic       event_extended,
    output logic       event_release,
    output logic [7:0] led               // Code of the last make event
);

    logic ext_pending;                   // E0 seen, waiting for the code
    logic rel_pending;                   // F0 seen, waiting for the code
    logic is_ext_prefix;
    logic is_rel_prefix;

    assign is_ext_prefix = (byte_data == key_pkg::PREFIX_EXTENDED);
    assign is_rel_prefix = (byte_data == key_pkg::PREFIX_RELEASE);

    // --------------------------------------
    // Prefix FSM and event strobe
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ext_pending <= 1'b0;
            rel_pending <= 1'b0;
            event_valid <= 1'b0;
            led         <= 8'h00;
        end else begin
            event_valid <= 1'b0;
            if (frame_error) begin
                // Lost byte may have been a prefix or a code, start clean
                ext_pending <= 1'b0;
                rel_pending <= 1'b0;
            end else if (byte_valid) begin
                if (is_ext_prefix) begin
                    ext_pending <= 1'b1;
                end else if (is_rel_prefix) begin
                    rel_pending <= 1'b1;         // E0 F0 keeps both set
                end else begin
                    event_valid <= 1'b1;
                    ext_pending <= 1'b0;         // Prefixes belong to this code only
                    rel_pending <= 1'b0;
                    if (!rel_pending) begin
                        led <= byte_data;        // Make events only
                    end
                end
            end
        end
    end

    // Event payload, qualified by event_valid downstream
    always_ff @(posedge clk) begin
        if (byte_valid && !is_ext_prefix && !is_rel_prefix) begin
            event_code     <= byte_data;
            event_extended <= ext_pending;
            event_release  <= rel_pending;
        end
    end

endmodule

/* logic/key_event_queue.sv */
// --------------------------------------
// Key event FIFO with credit-based output
// Drops on full, sends only while credit remains
// --------------------------------------

`timescale 1ns/1ns

module key_event_queue (
    input  logic       clk,
    input  logic       rst,
    input  logic       event_valid,
    input  logic [7:0] event_code,
    input  logic       event_extended,
    input  logic       event_release,
    output logic       key_valid,      // One cycle per delivered event
    output logic [7:0] key_code,
    output logic       key_extended,
    output logic       key_release,
    input  logic       key_credit,     // Consumer hands back one slot
    output logic       key_dropped     // Event arrived with the FIFO full
);

    // Entry layout: {extended, release, code}
    logic [9:0] mem [key_pkg::QUEUE_DEPTH];

    logic [key_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [key_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [key_pkg::QUEUE_PTR_W:0]   count;     // Stored events, one extra bit for full
    logic [key_pkg::CREDIT_W-1:0]    credit;    // Free slots at the consumer

    logic full;
    logic empty;
    logic wr_en;
    logic send;

    assign full  = (count == (key_pkg::QUEUE_PTR_W + 1)'(key_pkg::QUEUE_DEPTH));
    assign empty = (count == '0);
    assign wr_en = event_valid & ~full;         // Write to a full FIFO is lost
    assign send  = ~empty & (credit != '0);

    // --------------------------------------
    // Storage and output register
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {event_extended, event_release, event_code};
        end
        if (send) begin
            {key_extended, key_release, key_code} <= mem[rd_ptr];
        end
    end

    // --------------------------------------
    // Pointers, occupancy and credit
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credit      <= (key_pkg::CREDIT_W)'(key_pkg::CONSUMER_CREDITS);
            key_valid   <= 1'b0;
            key_dropped <= 1'b0;
        end else begin
            key_valid   <= send;
            key_dropped <= event_valid & full;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;            // Depth is a power of two
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither
            endcase
            // Returned credit and a transfer in one cycle cancel out
            case ({key_credit, send})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

endmodule

/* logic/ps2_keyboard_top.sv */
// --------------------------------------
// PS/2 keyboard subsystem top level
// Receiver, prefix decoder, event queue
// --------------------------------------

`timescale 1ns/1ns

module ps2_keyboard_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,        // Async keyboard clock
    input  logic       ps2_data,       // Async keyboard data
    output logic       key_valid,
    output logic [7:0] key_code,
    output logic       key_extended,
    output logic       key_release,
    input  logic       key_credit,
    output logic       frame_error,
    output logic       key_dropped,
    output logic [7:0] led
);

    // Receiver to decoder
    logic       byte_valid;
    logic [7:0] byte_data;

    // Decoder to queue
    logic       event_valid;
    logic [7:0] event_code;
    logic       event_extended;
    logic       event_release;

    ps2_frame_rx i_rx (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_error (frame_error)      // Also goes out as a status pulse
    );

    scan_event_decoder i_decoder (
        .clk            (clk),
        .rst            (rst),
        .byte_valid     (byte_valid),
        .byte_data      (byte_data),
        .frame_error    (frame_error),
        .event_valid    (event_valid),
        .event_code     (event_code),
        .event_extended (event_extended),
        .event_release  (event_release),
        .led            (led)
    );

    key_event_queue i_queue (
        .clk            (clk),
        .rst            (rst),
        .event_valid    (event_valid),
        .event_code     (event_code),
        .event_extended (event_extended),
        .event_release  (event_release),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .key_extended   (key_extended),
        .key_release    (key_release),
        .key_credit     (key_credit),
        .key_dropped    (key_dropped)
    );

endmodule

/* tb/tb_clock_gen.sv */
// --------------------------------------
// Testbench clock and reset
// 100 ns clock, reset high for two cycles
// --------------------------------------

`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;      // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;                 // Released on a rising edge
    end

endmodule

/* tb/ps2_keyboard_sva.sv */
// --------------------------------------
// Assertions bound to the keyboard top
// Credit use, receiver pulses, drop pulses
// --------------------------------------

`timescale 1ns/1ns

module ps2_keyboard_sva (
    input logic clk,
    input logic rst,
    input logic ps2_clk,
    input logic key_valid,
    input logic key_credit,
    input logic byte_valid,
    input logic frame_error,
    input logic event_valid,
    input logic key_dropped
);

    int   held;      // Consumer credit, key_valid lags the DUT transfer by a cycle
    int   fill;      // Entries in the FIFO plus any event on key_valid
    int   stored;    // Entries in the FIFO this cycle
    logic was_full;  // FIFO held QUEUE_DEPTH entries one cycle ago

    assign stored = fill - int'(key_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            held     <= key_pkg::CONSUMER_CREDITS;
            fill     <= 0;
            was_full <= 1'b0;
        end else begin
            held     <= held + int'(key_credit) - int'(key_valid);
            fill     <= stored + int'(event_valid && stored < key_pkg::QUEUE_DEPTH);
            was_full <= (stored >= key_pkg::QUEUE_DEPTH);
        end
    end

    // A credit returned in the cycle of the transfer was not yet usable
    credit_spent: assert property (@(posedge clk) disable iff (rst)
        key_valid |-> (held > int'($past(key_credit))))
        else $error("key_valid issued with no credit left");

    // Exclusive pulses, 3 clocks after a falling edge on the pin
    rx_pulses: assert property (@(posedge clk) disable iff (rst)
        (byte_valid || frame_error) |->
            !(byte_valid && frame_error) && !$past(ps2_clk, 3) && $past(ps2_clk, 4))
        else $error("byte_valid or frame_error out of step with the PS/2 clock");

    // Only an event that meets a full FIFO is dropped
    drop_cause: assert property (@(posedge clk) disable iff (rst)
        key_dropped |-> $past(event_valid) && was_full)
        else $error("key_dropped without an event meeting a full FIFO");

endmodule

bind ps2_keyboard_top ps2_keyboard_sva i_sva (
    .clk         (clk),
    .rst         (rst),
    .ps2_clk     (ps2_clk),
    .key_valid   (key_valid),
    .key_credit  (key_credit),
    .byte_valid  (byte_valid),
    .frame_error (frame_error),
    .event_valid (event_valid),
    .key_dropped (key_dropped)
);

/* tb/ps2_keyboard_tb.sv */
// --------------------------------------
// PS/2 keyboard subsystem testbench
// Keyboard frame model, credit consumer,
// reference model of prefixes, queue and LEDs
// --------------------------------------

`timescale 1ns/1ns

module ps2_keyboard_tb;

    logic       clk;
    logic       rst;
    logic       ps2_clk    = 1'b1;      // Lines idle high
    logic       ps2_data   = 1'b1;
    logic       key_credit = 1'b0;
    logic       key_valid;
    logic [7:0] key_code;
    logic       key_extended;
    logic       key_release;
    logic       frame_error;
    logic       key_dropped;
    logic [7:0] led;

    logic [31:0] rng      = 32'd96;     // Stimulus stream
    logic [31:0] cons_rng = 32'd96;     // Consumer delays, own stream

    // Reference model
    logic       m_ext     = 1'b0;
    logic       m_rel     = 1'b0;
    logic [7:0] m_led     = 8'h00;
    logic [9:0] exp_q [$];              // {extended, release, code}
    logic [9:0] exp_ev;
    int         exp_err   = 0;
    int         exp_drop  = 0;
    int         err_seen  = 0;
    int         drop_seen = 0;
    int         avail     = 0;          // Credit the DUT may still spend
    int         owed      = 0;          // Events not yet paid back
    int         delivered = 0;
    int         credit_delay = 0;
    logic       withhold  = 1'b0;       // Consumer keeps its credits

    tb_clock_gen i_clk_gen (.clk(clk), .rst(rst));

    ps2_keyboard_top i_dut (
        .clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .key_valid(key_valid), .key_code(key_code), .key_extended(key_extended),
        .key_release(key_release), .key_credit(key_credit),
        .frame_error(frame_error), .key_dropped(key_dropped), .led(led)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Any byte except E0 and F0
    function automatic logic [7:0] random_code();
        rng = xorshift(rng);
        if (rng[7:0] == 8'hE0 || rng[7:0] == 8'hF0) return rng[7:0] ^ 8'h01;
        return rng[7:0];
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // --------------------------------------
    // Monitor and consumer
    // --------------------------------------
    always @(negedge clk) begin
        if (rst) begin
            avail = key_pkg::CONSUMER_CREDITS;
        end else begin
            if (key_valid) begin
                if (avail == 0) begin
                    $display("key_valid fired while the consumer held no credit");
                    abort_run();
                end
                if (exp_q.size() == 0) begin
                    $display("Unexpected key event with code 0x%0h", key_code);
                    abort_run();
                end
                exp_ev = exp_q.pop_front();        // Arrival order
                check_value("key_code", 32'(key_code), 32'(exp_ev[7:0]));
                check_value("key_extended", 32'(key_extended), 32'(exp_ev[9]));
                check_value("key_release", 32'(key_release), 32'(exp_ev[8]));
                avail = avail - 1;
                owed = owed + 1;
                delivered = delivered + 1;
            end
            if (key_credit) avail = avail + 1;     // DUT counts it on the next edge
            if (frame_error) err_seen = err_seen + 1;
            if (key_dropped) drop_seen = drop_seen + 1;
        end
    end

    always @(posedge clk) begin
        key_credit <= 1'b0;
        if (!rst && credit_delay > 0) begin
            credit_delay = credit_delay - 1;
        end else if (!rst && owed > 0 && !withhold) begin
            key_credit <= 1'b1;                   // One credit per event
            owed = owed - 1;
            cons_rng = xorshift(cons_rng);
            credit_delay = (cons_rng[2:0] == 3'd0) ? 60 : int'(cons_rng[7:4]);
        end
    end

    // --------------------------------------
    // Keyboard model
    // --------------------------------------
    // kind 0 good, 1 bad start, 2 bad stop, 3 bad parity, 4 cut short
    task automatic drive_frame(input logic [7:0] b, input int kind);
        logic [10:0] bits;
        int          nbits;
        int          i;
        bits = {1'b1, ~^b, b, 1'b0};              // Stop, odd parity, data, start
        case (kind)
            1: bits[0] = 1'b1;
            2: bits[10] = 1'b0;
            3: bits[9] = ~bits[9];
            default: ;
        endcase
        nbits = 11;
        if (kind == 4) begin
            rng = xorshift(rng);
            nbits = 1 + int'(rng % 10);
        end
        for (i = 0; i < nbits; i++) begin
            @(posedge clk) ps2_data <= bits[i];   // Data changes while clock high
            repeat (6) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (6) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        @(posedge clk) ps2_data <= 1'b1;
    endtask

    task automatic model_frame(input logic [7:0] b, input int kind);
        if (kind == 0 && b == 8'hE0) begin
            m_ext = 1'b1;
        end else if (kind == 0 && b == 8'hF0) begin
            m_rel = 1'b1;
        end else if (kind == 0) begin
            if (!m_rel) m_led = b;                // Make codes only
            if (exp_q.size() >= key_pkg::QUEUE_DEPTH) exp_drop = exp_drop + 1;
            else exp_q.push_back({m_ext, m_rel, b});
            m_ext = 1'b0;
            m_rel = 1'b0;
        end else if (kind < 4) begin
            exp_err = exp_err + 1;                // Bad frame clears prefixes
            m_ext = 1'b0;
            m_rel = 1'b0;
        end
    endtask

    task automatic run_frame(input logic [7:0] b, input int kind);
        int timer;
        model_frame(b, kind);
        drive_frame(b, kind);
        if (kind == 4) repeat (ps2_pkg::RX_TIMEOUT_CYCLES + 100) @(posedge clk);
        timer = 0;
        while (!(err_seen == exp_err && drop_seen == exp_drop
                 && (withhold || exp_q.size() == 0))) begin
            @(posedge clk);
            timer = timer + 1;
            if (timer > 2000) begin
                $display("Timed out waiting for the outcome of byte 0x%0h", b);
                abort_run();
            end
        end
        rng = xorshift(rng);
        repeat (20 + int'(rng[4:0])) @(posedge clk);   // Idle gap
        check_value("frame_error count", 32'(err_seen), 32'(exp_err));
        check_value("key_dropped count", 32'(drop_seen), 32'(exp_drop));
        @(negedge clk);
        check_value("led", 32'(led), 32'(m_led));
    endtask

    // --------------------------------------
    // Test sequence
    // --------------------------------------
    initial begin
        int   timer;
        int   kind;
        int   base;
        logic [1:0] sel;
        timer = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            timer = timer + 1;
            if (timer > 20) begin
                $display("Reset never released");
                abort_run();
            end
        end
        repeat (8) begin
            @(negedge clk);
            check_value("key_valid", 32'(key_valid), 32'd0);
            check_value("frame_error", 32'(frame_error), 32'd0);
            check_value("key_dropped", 32'(key_dropped), 32'd0);
            check_value("led", 32'(led), 32'd0);
        end
        repeat (12) run_frame(random_code(), 0);            // Plain make codes
        repeat (16) begin                                  // E0, F0, E0 F0
            rng = xorshift(rng);
            sel = rng[1:0];
            if (sel[0]) run_frame(8'hE0, 0);
            if (sel[1]) run_frame(8'hF0, 0);
            run_frame(random_code(), 0);
        end
        repeat (9) begin                                   // Bad frames after prefixes
            rng = xorshift(rng);
            sel = rng[1:0];
            kind = 1 + int'(rng[15:8] % 3);
            if (sel[0]) run_frame(8'hE0, 0);
            if (sel[1]) run_frame(8'hF0, 0);
            run_frame(random_code(), kind);
            run_frame(random_code(), 0);
        end
        repeat (4) begin                                   // Cut frames then silence
            run_frame(random_code(), 4);
            run_frame(random_code(), 0);
        end
        timer = 0;
        while (avail != key_pkg::CONSUMER_CREDITS || owed != 0) begin
            @(posedge clk);
            timer = timer + 1;
            if (timer > 1000) begin
                $display("Consumer credits never came home");
                abort_run();
            end
        end
        withhold = 1'b1;
        base = delivered;
        repeat (key_pkg::CONSUMER_CREDITS + key_pkg::QUEUE_DEPTH + 2) begin
            run_frame(random_code(), 0);
        end
        check_value("delivered events", 32'(delivered - base), 32'(key_pkg::CONSUMER_CREDITS));
        check_value("queued events", 32'(exp_q.size()), 32'(key_pkg::QUEUE_DEPTH));
        withhold = 1'b0;                                   // Backlog drains in order
        timer = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            timer = timer + 1;
            if (timer > 3000) begin
                $display("Stored events not delivered after credits returned");
                abort_run();
            end
        end
        run_frame(random_code(), 0);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* vlog.f */
logic/ps2_pkg.sv
logic/key_pkg.sv
logic/ps2_frame_rx.sv
logic/scan_event_decoder.sv
logic/key_event_queue.sv
logic/ps2_keyboard_top.sv
tb/tb_clock_gen.sv
tb/ps2_keyboard_sva.sv
tb/ps2_keyboard_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PS/2 keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module ps2_keyboard_tb -o sim_ps2_keyboard
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ps2_keyboard 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi
